// ==== include/read_bus_consts.svh ====
`ifndef READ_BUS_CONSTS_SVH
`define READ_BUS_CONSTS_SVH

// ************************************************************
// shared read bus sizing
// ************************************************************

// masters on the bus, lowest index has highest priority.
`define NUM_MASTERS 3

// consecutive enabled bus cycles before the target answers.
`define MEM_LATENCY 3

// mixed into every read word.
`define MEM_PATTERN 32'h5a3c_96e1

// address and data width.
`define ADDR_W 32

`endif

// ==== verilog/read_bus_pkg.sv ====
`include "read_bus_consts.svh"

package read_bus_pkg;

    // bus address and read data word.
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`ADDR_W-1:0] word_t;

    // ************************************************************
    // master controller states
    // ************************************************************
    typedef enum logic [1:0] {
        MS_IDLE = 2'b00, // accepts requests, passes grant.
        MS_ARB  = 2'b01, // address held, waiting for grant.
        MS_BUS  = 2'b10  // owns the bus until data arrives.
    } master_state_t;

endpackage

// ==== verilog/read_master.sv ====
module read_master (
    input  logic                clk,
    input  logic                rst,

    input  logic                req_valid,
    output logic                req_ready,
    input  read_bus_pkg::addr_t req_address,
    output logic                dp_valid,
    output read_bus_pkg::word_t dp_read_data,

    output read_bus_pkg::addr_t mem_addr,
    output logic                mem_req,
    output logic                mem_en,
    input  logic                mem_data_valid,
    input  read_bus_pkg::word_t mem_data,

    input  logic                grant_in,
    output logic                grant_out,
    input  logic                busy_in
);
    import read_bus_pkg::*;

    master_state_t state;
    master_state_t state_next;
    addr_t         req_addr;
    logic          req_take;
    logic          bus_win;

    // ************************************************************
    // request side
    // ************************************************************
    assign req_ready = (state == MS_IDLE);
    assign req_take  = req_ready & req_valid;

    always_ff @(posedge clk) begin
        if (req_take) begin
            req_addr <= req_address;
        end
    end

    // grant only moves down the chain past an idle, quiet master.
    assign grant_out = grant_in & req_ready & ~req_valid;

    // ************************************************************
    // bus side
    // ************************************************************
    assign bus_win  = (state == MS_ARB) & grant_in & ~busy_in;
    assign mem_en   = (state == MS_BUS);
    assign mem_req  = bus_win | mem_en;
    assign mem_addr = mem_en ? req_addr : '0; // stands in for the tristate driver.

    assign dp_valid     = mem_en & mem_data_valid; // ignore data meant for others.
    assign dp_read_data = mem_data;

    // ************************************************************
    // controller
    // ************************************************************
    always_comb begin
        state_next = state;
        case (state)
            MS_IDLE: begin
                if (req_valid) begin
                    state_next = MS_ARB;
                end
            end
            MS_ARB: begin
                if (bus_win) begin
                    state_next = MS_BUS;
                end
            end
            MS_BUS: begin
                if (mem_data_valid) begin
                    state_next = MS_IDLE; // one read per tenure.
                end
            end
            default: begin
                state_next = MS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MS_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== verilog/bus_merge.sv ====
`include "read_bus_consts.svh"

module bus_merge (
    input  read_bus_pkg::addr_t [`NUM_MASTERS-1:0] master_addr,
    input  logic [`NUM_MASTERS-1:0]                master_en,
    output read_bus_pkg::addr_t                    bus_addr,
    output logic                                   bus_en,
    output logic [`NUM_MASTERS-1:0]                busy_in
);

    // ************************************************************
    // address merge
    // ************************************************************

    // wired-or of the gated drivers.
    always_comb begin
        bus_addr = '0;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            if (master_en[i]) begin
                bus_addr = bus_addr | master_addr[i];
            end
        end
    end

    assign bus_en = |master_en;

    // ************************************************************
    // busy fan-out
    // ************************************************************

    // each master sees only the other masters' enables,
    // so its own tenure never blocks itself.
    always_comb begin
        busy_in = '0;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            for (int j = 0; j < `NUM_MASTERS; j++) begin
                if (j != i) begin
                    busy_in[i] = busy_in[i] | master_en[j];
                end
            end
        end
    end

endmodule

// ==== verilog/pattern_mem_target.sv ====
`include "read_bus_consts.svh"

module pattern_mem_target (
    input  logic                clk,
    input  logic                rst,
    input  logic                bus_en,
    input  read_bus_pkg::addr_t bus_addr,
    output logic                mem_data_valid,
    output read_bus_pkg::word_t mem_data
);
    import read_bus_pkg::*;

    localparam int               CNT_W    = $clog2(`MEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`MEM_LATENCY - 1);

    logic [CNT_W-1:0] cyc_cnt; // enabled cycles seen this tenure.
    word_t            rotated;

    // ************************************************************
    // response data
    // ************************************************************
    assign rotated  = {bus_addr[`ADDR_W-9:0], bus_addr[`ADDR_W-1:`ADDR_W-8]};
    assign mem_data = rotated ^ word_t'(`MEM_PATTERN);

    // strobe on the last counted cycle.
    assign mem_data_valid = bus_en && (cyc_cnt == LAST_CNT);

    // ************************************************************
    // latency counter
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt <= '0;
        end else if (!bus_en || mem_data_valid) begin
            cyc_cnt <= '0; // restart for the next tenure.
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/read_bus_sys.sv ====
`include "read_bus_consts.svh"

module read_bus_sys (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [`NUM_MASTERS-1:0]                req_valid,
    output logic [`NUM_MASTERS-1:0]                req_ready,
    input  read_bus_pkg::addr_t [`NUM_MASTERS-1:0] req_address,
    output logic [`NUM_MASTERS-1:0]                dp_valid,
    output read_bus_pkg::word_t                    dp_read_data
);
    import read_bus_pkg::*;

    addr_t [`NUM_MASTERS-1:0] master_addr;
    logic [`NUM_MASTERS-1:0]  master_en;
    logic [`NUM_MASTERS-1:0]  busy_in;
    logic [`NUM_MASTERS:0]    grant_chain;
    addr_t                    bus_addr;
    logic                     bus_en;
    logic                     mem_data_valid;
    word_t                    mem_data;

    assign grant_chain[0] = 1'b1; // head of the chain always granted.
    assign dp_read_data   = mem_data;

    // ************************************************************
    // masters
    // ************************************************************
    for (genvar i = 0; i < `NUM_MASTERS; i++) begin : g_master
        read_master master_inst (
            .clk            (clk),
            .rst            (rst),
            .req_valid      (req_valid[i]),
            .req_ready      (req_ready[i]),
            .req_address    (req_address[i]),
            .dp_valid       (dp_valid[i]),
            .dp_read_data   (),
            .mem_addr       (master_addr[i]),
            .mem_req        (),
            .mem_en         (master_en[i]),
            .mem_data_valid (mem_data_valid),
            .mem_data       (mem_data),
            .grant_in       (grant_chain[i]),
            .grant_out      (grant_chain[i+1]),
            .busy_in        (busy_in[i])
        );
    end

    bus_merge bus_merge_inst (
        .master_addr (master_addr),
        .master_en   (master_en),
        .bus_addr    (bus_addr),
        .bus_en      (bus_en),
        .busy_in     (busy_in)
    );

    pattern_mem_target mem_target_inst (
        .clk            (clk),
        .rst            (rst),
        .bus_en         (bus_en),
        .bus_addr       (bus_addr),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data)
    );

endmodule

// ==== tests/read_bus_sys_asserts.sv ====
`include "read_bus_consts.svh"

module read_bus_sys_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic [`NUM_MASTERS-1:0] master_en,
    input logic [`NUM_MASTERS-1:0] dp_valid,
    input logic                    bus_en,
    input logic                    mem_data_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // ************************************************************
    // bus protocol
    // ************************************************************

    // single bus owner.
    one_owner: assert property (@(posedge clk) disable iff (rst) $onehot0(master_en))
        else $error("more than one master owns the bus");

    one_answer: assert property (@(posedge clk) disable iff (rst) $onehot0(dp_valid))
        else $error("dp_valid asserted on more than one channel");

    // target answers within the tenure, on its last latency cycle.
    answer_on_time: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_en) |-> ##(`MEM_LATENCY - 1) (bus_en && mem_data_valid))
        else $error("mem_data_valid missing at the end of the bus latency");

    bus_free_after_reset: assert property (@(posedge clk) rst |=> master_en == '0)
        else $error("a master drives the bus right after reset");

endmodule

bind read_bus_sys read_bus_sys_asserts asserts_inst (
    .clk            (clk),
    .rst            (rst),
    .master_en      (master_en),
    .dp_valid       (dp_valid),
    .bus_en         (bus_en),
    .mem_data_valid (mem_data_valid)
);

// ==== tests/read_bus_sys_tb.sv ====
`include "read_bus_consts.svh"

module read_bus_sys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import read_bus_pkg::*;

    logic                           clk = 1'b0;
    logic                           rst;
    logic [`NUM_MASTERS-1:0]        req_valid;
    logic [`NUM_MASTERS-1:0]        req_ready;
    addr_t [`NUM_MASTERS-1:0]       req_address;
    logic [`NUM_MASTERS-1:0]        dp_valid;
    word_t                          dp_read_data;

    word_t exp_q [`NUM_MASTERS][$]; // answers still owed per channel.
    int    checks     = 0;
    int    value_errs = 0;
    int    other_errs = 0;

    always #4 clk = ~clk;

    read_bus_sys read_bus_sys_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_address  (req_address),
        .dp_valid     (dp_valid),
        .dp_read_data (dp_read_data)
    );

    // ************************************************************
    // reference model and compare tasks
    // ************************************************************
    function automatic word_t read_model(input addr_t addr);
        word_t rot;
        rot = (addr << 8) | (addr >> (`ADDR_W - 8)); // rotate left by one byte.
        return rot ^ `MEM_PATTERN;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin : monitor
        word_t exp_word;
        if (!rst) begin
            for (int i = 0; i < `NUM_MASTERS; i++) begin
                // ready only while nothing is owed.
                check_bit($sformatf("req_ready[%0d]", i), exp_q[i].size() == 0, req_ready[i]);
                if (dp_valid[i]) begin
                    if (exp_q[i].size() == 0) begin
                        other_errs++;
                        $display("dp_valid[%0d] at %0t came without an open request", i, $time);
                    end else begin
                        exp_word = exp_q[i].pop_front();
                        check_word("dp_read_data", exp_word, dp_read_data);
                    end
                end
                if (req_valid[i] && req_ready[i]) begin
                    exp_q[i].push_back(read_model(req_address[i]));
                end
            end
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (pending() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pending() != 0) begin
            other_errs++;
            $display("timed out with %0d requests still unanswered", pending());
        end
    endtask

    task automatic single_read(input int ch, input addr_t addr);
        @(negedge clk);
        req_valid[ch]   = 1'b1;
        req_address[ch] = addr;
        @(posedge clk); // idle system, taken here.
        @(negedge clk);
        req_valid[ch] = 1'b0;
        for (int k = 1; k <= `MEM_LATENCY + 1; k++) begin
            @(posedge clk);
            check_bit($sformatf("dp_valid[%0d]", ch), k == `MEM_LATENCY + 1, dp_valid[ch]);
        end
    endtask

    task automatic burst_all(input int limit);
        int n;
        @(negedge clk);
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            req_valid[i]   = 1'b1;
            req_address[i] = $urandom();
        end
        @(posedge clk);
        @(negedge clk);
        req_valid = '0;
        for (int seen = 0; seen < `NUM_MASTERS; seen++) begin
            n = 0;
            @(posedge clk);
            while (dp_valid == '0 && n < limit) begin
                @(posedge clk);
                n++;
            end
            if (dp_valid == '0) begin
                other_errs++;
                $display("timed out waiting for answer %0d of a same-cycle burst", seen);
                return;
            end
            check_bit($sformatf("dp_valid[%0d]", seen), 1'b1, dp_valid[seen]); // lowest first.
        end
    endtask

    task automatic run_random(input int cycles);
        int                      gap [`NUM_MASTERS];
        logic [`NUM_MASTERS-1:0] took;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            gap[i] = $urandom_range(0, 7);
        end
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            took = req_valid & req_ready;
            @(negedge clk);
            for (int i = 0; i < `NUM_MASTERS; i++) begin
                if (took[i]) begin
                    req_valid[i] = 1'b0;
                    gap[i]       = $urandom_range(0, 7);
                end else if (!req_valid[i]) begin
                    if (gap[i] == 0) begin
                        req_valid[i]   = 1'b1;
                        req_address[i] = $urandom();
                    end else begin
                        gap[i]--;
                    end
                end
            end
        end
        req_valid = '0; // unaccepted requests are simply withdrawn.
    endtask

    initial begin
        rst         = 1'b1;
        req_valid   = '0;
        req_address = '0;
        void'($urandom(32'h11a5));
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk); // quiet bus after reset.

        for (int i = 0; i < `NUM_MASTERS; i++) begin
            single_read(i, $urandom());
            wait_drain(100);
        end
        burst_all(200);
        wait_drain(200);
        run_random(4000);
        wait_drain(2000);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== read_bus_sys.f ====
+incdir+include
verilog/read_bus_pkg.sv
verilog/read_master.sv
verilog/bus_merge.sv
verilog/pattern_mem_target.sv
verilog/read_bus_sys.sv
tests/read_bus_sys_asserts.sv
tests/read_bus_sys_tb.sv

// ==== Bender.yml ====
package:
  name: read_bus_sys

sources:
  - include_dirs:
      - include
    files:
      - verilog/read_bus_pkg.sv
      - verilog/read_master.sv
      - verilog/bus_merge.sv
      - verilog/pattern_mem_target.sv
      - verilog/read_bus_sys.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/read_bus_sys_asserts.sv
      - tests/read_bus_sys_tb.sv
